//--- dv/core_monitor.sv
`timescale 1ns/1ns

module core_monitor (
   input logic                         clk,
   input logic                         arst_n,
   input logic                         in_valid,
   input logic                         in_ready,
   input logic [2:0]                   in_opcode,
   input logic [ooo_pkg::AREG_W-1:0]   in_rd,
   input logic [ooo_pkg::AREG_W-1:0]   in_rs,
   input logic [ooo_pkg::AREG_W-1:0]   in_rt,
   input logic [ooo_pkg::XLEN-1:0]     in_imm,
   input logic                         cdb_valid,
   input logic [ooo_pkg::TAG_W-1:0]    cdb_tag,
   input logic [ooo_pkg::XLEN-1:0]     cdb_data,
   input logic [ooo_pkg::XLEN-1:0]     dbg_data
);

   localparam int NTAG = 2 ** ooo_pkg::TAG_W;

   // In-order architectural state and the value each tag in flight must carry.
   logic [ooo_pkg::XLEN-1:0]  model       [8];
   logic [ooo_pkg::XLEN-1:0]  expect_data [NTAG];
   logic                      pending     [NTAG];
   logic [ooo_pkg::TAG_W-1:0] tag_pred;
   int                        outstanding     = 0;
   int                        stalls          = 0;
   int                        errors          = 0;
   int                        readback_errors = 0;

   function automatic logic [31:0] model_result(input logic [2:0] op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [31:0] imm);
      case (ooo_pkg::op_e'(op))
         ooo_pkg::op_add: return a + b;
         ooo_pkg::op_sub: return a - b;
         ooo_pkg::op_and: return a & b;
         ooo_pkg::op_or:  return a | b;
         ooo_pkg::op_sll: return a << b[4:0];
         ooo_pkg::op_srl: return a >> b[4:0];
         ooo_pkg::op_mul: return a * b;
         default:         return imm;
      endcase
   endfunction

   // Sampled on the falling edge, half a cycle away from every change.
   always @(negedge clk) begin
      logic [31:0] result;
      if (!arst_n) begin
         for (int i = 0; i < 8; i++) begin
            model[i] = '0;
         end
         for (int i = 0; i < NTAG; i++) begin
            pending[i] = 1'b0;
         end
         tag_pred    = 6'd1;
         outstanding = 0;
      end else begin
         if (cdb_valid) begin
            if (!pending[cdb_tag]) begin
               $display("ERROR %0t: CDB broadcast of tag %0d, which is not in flight",
                        $time, cdb_tag);
               errors++;
            end else begin
               if (cdb_data !== expect_data[cdb_tag]) begin
                  $display("ERROR %0t: tag %0d broadcast %h, expected %h", $time, cdb_tag,
                           cdb_data, expect_data[cdb_tag]);
                  errors++;
               end
               pending[cdb_tag] = 1'b0;
               outstanding--;
            end
         end
         if (in_valid && !in_ready) begin
            stalls++;
         end
         if (in_valid && in_ready) begin
            result                = model_result(in_opcode, model[in_rs], model[in_rt], in_imm);
            model[in_rd]          = result;
            expect_data[tag_pred] = result;
            pending[tag_pred]     = 1'b1;
            outstanding++;
            // Tags count 1 to 63 and then start over at 1.
            tag_pred = (tag_pred == 6'd63) ? 6'd1 : tag_pred + 6'd1;
         end
      end
   end

   task automatic check_reg(input logic [2:0] addr, input logic [31:0] expected);
      if (dbg_data !== expected || dbg_data !== model[addr]) begin
         $display("ERROR %0t: r%0d reads %h, expected %h, in-order model has %h", $time, addr,
                  dbg_data, expected, model[addr]);
         readback_errors++;
      end
   endtask

endmodule

//--- dv/core_patterns.txt
// Columns: kind opcode rd rs rt imm gap. Kind 1 dispatches one instruction, then idles gap cycles.
// Kind 2 is a final readback: register in the rd column, expected value in the imm column.
1 7 1 0 0 00000005 0
1 7 2 0 0 00000003 0
1 0 3 1 2 00000000 0
1 1 4 3 2 00000000 1
1 4 5 4 2 00000000 2
1 3 6 5 1 00000000 0
1 2 7 6 3 00000000 0
1 5 0 6 1 00000000 3
1 6 3 1 2 00000000 0
1 6 4 1 1 00000000 0
1 6 5 2 2 00000000 0
1 6 6 1 2 00000000 0
1 6 7 2 1 00000000 0
1 6 0 1 1 00000000 0
1 6 1 1 2 00000000 0
1 0 2 1 1 00000000 0
1 7 3 0 0 0000abcd 0
1 1 4 3 2 00000000 0
1 7 5 0 0 ffffffff 0
1 4 5 5 2 00000000 0
1 0 6 5 4 00000000 0
2 0 0 0 0 00000019 0
2 0 1 0 0 0000000f 0
2 0 2 0 0 0000001e 0
2 0 3 0 0 0000abcd 0
2 0 4 0 0 0000abaf 0
2 0 5 0 0 c0000000 0
2 0 6 0 0 c000abaf 0
2 0 7 0 0 0000000f 0

//--- dv/ooo_chk.sv
`timescale 1ns/1ns

module ooo_chk (
   input logic clk,
   input logic arst_n,
   input logic in_ready,
   input logic cdb_valid,
   input logic iq_ready,
   input logic iq_done
);

   int fail_count = 0;

   // An entry offered to the execution unit stays offered until the unit takes it.
   a_offer_held: assert property (@(posedge clk) disable iff (!arst_n)
                                  iq_ready && !iq_done |=> iq_ready)
      else begin
         $error("the queue withdrew its ready entry before issue done");
         fail_count++;
      end

   // Results are one-cycle pulses and never come back to back.
   a_cdb_pulse: assert property (@(posedge clk) disable iff (!arst_n)
                                 cdb_valid |=> !cdb_valid)
      else begin
         $error("cdb_valid stayed high for two consecutive cycles");
         fail_count++;
      end

   // The queue leaves reset empty, so dispatch is open right away.
   a_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> in_ready)
      else begin
         $error("in_ready was low in the first cycle after reset");
         fail_count++;
      end

endmodule

bind ooo_int_core ooo_chk u_chk (
   .clk(clk), .arst_n(arst_n), .in_ready(in_ready), .cdb_valid(cdb_valid),
   .iq_ready(iq.ready), .iq_done(iq.done)
);

//--- dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;

   localparam int QUEUE_DEPTH = 4;
   localparam int MUL_LATENCY = 4;
   localparam int REC_W       = 7;
   localparam int MAX_REC     = 48;
   localparam int WAIT_LIMIT  = 100;

   logic                       clk;
   logic                       arst_n;
   logic                       in_valid;
   logic [2:0]                 in_opcode;
   logic [ooo_pkg::AREG_W-1:0] in_rd;
   logic [ooo_pkg::AREG_W-1:0] in_rs;
   logic [ooo_pkg::AREG_W-1:0] in_rt;
   logic [ooo_pkg::XLEN-1:0]   in_imm;
   logic                       in_ready;
   logic                       cdb_valid;
   logic [ooo_pkg::TAG_W-1:0]  cdb_tag;
   logic [ooo_pkg::XLEN-1:0]   cdb_data;
   logic [ooo_pkg::AREG_W-1:0] dbg_addr;
   logic [ooo_pkg::XLEN-1:0]   dbg_data;

   // Each pattern record is seven words: kind, opcode, rd, rs, rt, imm, gap.
   logic [31:0]                pat [REC_W*MAX_REC];
   int                         tb_errors;
   int                         total;

   ooo_int_core #(.QUEUE_DEPTH(QUEUE_DEPTH), .MUL_LATENCY(MUL_LATENCY)) dut (
      .clk, .arst_n, .in_valid, .in_opcode, .in_rd, .in_rs, .in_rt, .in_imm, .in_ready,
      .cdb_valid, .cdb_tag, .cdb_data, .dbg_addr, .dbg_data
   );

   core_monitor u_mon (
      .clk, .arst_n, .in_valid, .in_ready, .in_opcode, .in_rd, .in_rs, .in_rt, .in_imm,
      .cdb_valid, .cdb_tag, .cdb_data, .dbg_data
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Inputs change only at this point, 5 ns after a rising edge.
   task automatic next_cycle();
      @(posedge clk);
      #5;
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!in_ready && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (!in_ready) begin
         $display("Timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
         tb_errors++;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (u_mon.outstanding != 0 && n < WAIT_LIMIT) begin
         next_cycle();
         n++;
      end
      if (u_mon.outstanding != 0) begin
         $display("Timeout: %0d accepted instructions never appeared on the CDB",
                  u_mon.outstanding);
         tb_errors++;
      end
   endtask

   // The instruction is held until the DUT takes it, then the bus idles for gap cycles.
   task automatic send(input int b);
      in_valid  = 1'b1;
      in_opcode = pat[b+1][2:0];
      in_rd     = pat[b+2][2:0];
      in_rs     = pat[b+3][2:0];
      in_rt     = pat[b+4][2:0];
      in_imm    = pat[b+5];
      wait_ready();
      next_cycle();
      in_valid = 1'b0;
      repeat (int'(pat[b+6])) next_cycle();
   endtask

   task automatic read_reg(input logic [2:0] addr, input logic [31:0] expected);
      dbg_addr = addr;
      @(negedge clk);
      u_mon.check_reg(addr, expected);
      next_cycle();
   endtask

   initial begin
      arst_n    = 1'b0;
      in_valid  = 1'b0;
      in_opcode = '0;
      in_rd     = '0;
      in_rs     = '0;
      in_rt     = '0;
      in_imm    = '0;
      dbg_addr  = '0;
      tb_errors = 0;
      for (int i = 0; i < REC_W*MAX_REC; i++) begin
         pat[i] = '0;
      end
      $readmemh("dv/core_patterns.txt", pat);
      repeat (4) @(posedge clk);
      #5;
      arst_n = 1'b1;

      // The register file must come out of reset cleared, with the CDB quiet.
      for (int r = 0; r < 8; r++) begin
         read_reg(3'(r), '0);
      end

      for (int k = 0; k < MAX_REC; k++) begin
         if (pat[k*REC_W] == 32'd1) begin
            send(k*REC_W);
         end
      end
      wait_drain();
      repeat (2) next_cycle();

      if (u_mon.stalls == 0) begin
         $display("The multiply burst never filled the queue, in_ready did not fall");
         tb_errors++;
      end
      for (int k = 0; k < MAX_REC; k++) begin
         if (pat[k*REC_W] == 32'd2) begin
            read_reg(pat[k*REC_W+2][2:0], pat[k*REC_W+5]);
         end
      end

      total = tb_errors + u_mon.errors + u_mon.readback_errors + dut.u_chk.fail_count;
      $display("Errors: monitor %0d, readback %0d, assertions %0d, testbench %0d",
               u_mon.errors, u_mon.readback_errors, dut.u_chk.fail_count, tb_errors);
      if (total == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- files.f
rtl/ooo_pkg.sv
rtl/dispatch_if.sv
rtl/issue_if.sv
rtl/dispatch_ctrl.sv
rtl/register_status.sv
rtl/issue_queue.sv
rtl/int_alu.sv
rtl/ooo_int_core.sv
dv/ooo_chk.sv
dv/core_monitor.sv
dv/tb_top.sv

//--- rtl/dispatch_ctrl.sv
`timescale 1ns/1ns

module dispatch_ctrl (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         in_valid,
   input  logic [2:0]                   in_opcode,
   input  logic [ooo_pkg::AREG_W-1:0]   in_rd,
   input  logic [ooo_pkg::AREG_W-1:0]   in_rs,
   input  logic [ooo_pkg::AREG_W-1:0]   in_rt,
   input  logic [ooo_pkg::XLEN-1:0]     in_imm,
   output logic                         in_ready,
   output logic [ooo_pkg::AREG_W-1:0]   lookup_rs,
   output logic [ooo_pkg::AREG_W-1:0]   lookup_rt,
   input  logic [ooo_pkg::TAG_W-1:0]    rs_tag,
   input  logic [ooo_pkg::XLEN-1:0]     rs_data,
   input  logic                         rs_valid,
   input  logic [ooo_pkg::TAG_W-1:0]    rt_tag,
   input  logic [ooo_pkg::XLEN-1:0]     rt_data,
   input  logic                         rt_valid,
   output logic                         alloc_we,
   output logic [ooo_pkg::AREG_W-1:0]   alloc_rd,
   output logic [ooo_pkg::TAG_W-1:0]    alloc_tag,
   dispatch_if.source                   dq
);

   logic [ooo_pkg::TAG_W-1:0] tag_q;
   logic                      accept;
   logic                      is_li;
   logic                      rs_ok;
   logic                      rt_ok;

   assign in_ready  = dq.ready;
   assign accept    = in_valid & dq.ready;
   assign is_li     = ooo_pkg::op_e'(in_opcode) == ooo_pkg::op_li;
   assign lookup_rs = in_rs;
   assign lookup_rt = in_rt;

   // The destination is renamed to the current tag at the accepting edge.
   assign alloc_we  = accept;
   assign alloc_rd  = in_rd;
   assign alloc_tag = tag_q;

   // A load-immediate needs no sources, so its immediate rides in the rs slot.
   assign rs_ok      = is_li | rs_valid;
   assign rt_ok      = is_li | rt_valid;
   assign dq.en      = accept;
   assign dq.opcode  = ooo_pkg::op_e'(in_opcode);
   assign dq.rdtag   = tag_q;
   assign dq.rsvalid = rs_ok;
   assign dq.rtvalid = rt_ok;
   assign dq.rstag   = rs_ok ? ooo_pkg::TAG_NONE : rs_tag;
   assign dq.rttag   = rt_ok ? ooo_pkg::TAG_NONE : rt_tag;
   assign dq.rsdata  = is_li ? in_imm : rs_data;
   assign dq.rtdata  = is_li ? '0 : rt_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tag_q <= ooo_pkg::TAG_FIRST;
      end else if (accept) begin
         tag_q <= ooo_pkg::next_tag(tag_q);
      end
   end

endmodule

//--- rtl/dispatch_if.sv
`timescale 1ns/1ns

interface dispatch_if;
   ooo_pkg::op_e                opcode;
   logic [ooo_pkg::TAG_W-1:0]   rdtag;
   logic [ooo_pkg::TAG_W-1:0]   rstag;
   logic [ooo_pkg::TAG_W-1:0]   rttag;
   logic [ooo_pkg::XLEN-1:0]    rsdata;
   logic [ooo_pkg::XLEN-1:0]    rtdata;
   logic                        rsvalid;
   logic                        rtvalid;
   logic                        en;
   logic                        ready;

   modport source (output opcode, rdtag, rstag, rttag, rsdata, rtdata, rsvalid, rtvalid, en,
                   input ready);
   modport sink (input opcode, rdtag, rstag, rttag, rsdata, rtdata, rsvalid, rtvalid, en,
                 output ready);
endinterface

//--- rtl/int_alu.sv
`timescale 1ns/1ns

module int_alu #(
   parameter int MUL_LATENCY = 4
) (
   input  logic          clk,
   input  logic          arst_n,
   issue_if.exec         iq,
   output ooo_pkg::cdb_t cdb
);

   localparam int CNT_W = $clog2(MUL_LATENCY + 1);

   logic                      busy;
   logic [CNT_W-1:0]          cnt;
   logic                      accept;
   logic [ooo_pkg::TAG_W-1:0] mul_tag;
   logic [ooo_pkg::XLEN-1:0]  mul_a;
   logic [ooo_pkg::XLEN-1:0]  mul_b;

   function automatic logic [ooo_pkg::XLEN-1:0] alu_op(input ooo_pkg::op_e op,
                                                       input logic [ooo_pkg::XLEN-1:0] a,
                                                       input logic [ooo_pkg::XLEN-1:0] b);
      case (op)
         ooo_pkg::op_add: return a + b;
         ooo_pkg::op_sub: return a - b;
         ooo_pkg::op_and: return a & b;
         ooo_pkg::op_or:  return a | b;
         ooo_pkg::op_sll: return a << b[4:0];
         ooo_pkg::op_srl: return a >> b[4:0];
         ooo_pkg::op_mul: return a * b;
         // Load-immediate already carries its value in rs.
         default:         return a;
      endcase
   endfunction

   // Idle also means the CDB is quiet, so broadcasts never come back to back.
   assign accept  = iq.ready & ~busy & ~cdb.valid;
   assign iq.done = accept;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= 1'b0;
         cnt  <= '0;
         cdb  <= '0;
      end else begin
         cdb.valid <= 1'b0;
         if (accept) begin
            if (iq.opcode == ooo_pkg::op_mul && MUL_LATENCY > 1) begin
               busy <= 1'b1;
               cnt  <= CNT_W'(MUL_LATENCY - 1);
            end else begin
               cdb <= '{valid: 1'b1, tag: iq.rdtag,
                        data: alu_op(iq.opcode, iq.rsdata, iq.rtdata)};
            end
         end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
               busy <= 1'b0;
               cdb  <= '{valid: 1'b1, tag: mul_tag, data: mul_a * mul_b};
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         mul_tag <= iq.rdtag;
         mul_a   <= iq.rsdata;
         mul_b   <= iq.rtdata;
      end
   end

endmodule

//--- rtl/issue_if.sv
`timescale 1ns/1ns

interface issue_if;
   ooo_pkg::op_e                opcode;
   logic [ooo_pkg::TAG_W-1:0]   rdtag;
   logic [ooo_pkg::XLEN-1:0]    rsdata;
   logic [ooo_pkg::XLEN-1:0]    rtdata;
   logic                        ready;
   logic                        done;

   // The queue offers its oldest ready entry and the unit takes it with done.
   modport queue (output opcode, rdtag, rsdata, rtdata, ready, input done);
   modport exec (input opcode, rdtag, rsdata, rtdata, ready, output done);
endinterface

//--- rtl/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic          clk,
   input  logic          arst_n,
   dispatch_if.sink      dq,
   input  ooo_pkg::cdb_t cdb,
   issue_if.queue        iq
);

   // Payload of one reservation station.
   typedef struct packed {
      ooo_pkg::op_e              opcode;
      logic [ooo_pkg::TAG_W-1:0] rdtag;
      logic [ooo_pkg::TAG_W-1:0] rstag;
      logic [ooo_pkg::TAG_W-1:0] rttag;
      logic [ooo_pkg::XLEN-1:0]  rsdata;
      logic [ooo_pkg::XLEN-1:0]  rtdata;
      logic                      rsvalid;
      logic                      rtvalid;
   } entry_t;

   logic [QUEUE_DEPTH-1:0] occ;
   logic [QUEUE_DEPTH-1:0] occ_nxt;
   entry_t                 q     [QUEUE_DEPTH];
   entry_t                 q_nxt [QUEUE_DEPTH];

   // Position QUEUE_DEPTH holds the instruction arriving from dispatch.
   logic [QUEUE_DEPTH:0]   slot_v;
   entry_t                 slot  [QUEUE_DEPTH+1];
   entry_t                 woken [QUEUE_DEPTH+1];

   logic [QUEUE_DEPTH-1:0] rdy;
   logic [QUEUE_DEPTH-1:0] sel;
   logic [QUEUE_DEPTH:0]   gone;

   assign slot_v = {dq.en, occ};

   // Wake-up. Every position, the incoming one included, snoops the CDB.
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         slot[i] = q[i];
      end
      slot[QUEUE_DEPTH] = '{opcode:  dq.opcode,
                            rdtag:   dq.rdtag,
                            rstag:   dq.rstag,
                            rttag:   dq.rttag,
                            rsdata:  dq.rsdata,
                            rtdata:  dq.rtdata,
                            rsvalid: dq.rsvalid,
                            rtvalid: dq.rtvalid};
      for (int i = 0; i <= QUEUE_DEPTH; i++) begin
         woken[i] = slot[i];
         if (!slot[i].rsvalid && cdb.valid && cdb.tag == slot[i].rstag) begin
            woken[i].rsdata  = cdb.data;
            woken[i].rsvalid = 1'b1;
         end
         if (!slot[i].rtvalid && cdb.valid && cdb.tag == slot[i].rttag) begin
            woken[i].rtdata  = cdb.data;
            woken[i].rtvalid = 1'b1;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         rdy[i] = occ[i] & q[i].rsvalid & q[i].rtvalid;
      end
   end

   // Lower slots are older, so the lowest set bit is the oldest ready entry.
   assign sel = rdy & (~rdy + 1'b1);

   // The incoming position never issues.
   assign gone = {1'b0, sel & {QUEUE_DEPTH{iq.done}}};

   // Collapse. An entry steps down one slot when the slot below is empty,
   // is being issued, or is itself stepping down. An issued entry does not move.
   always_comb begin
      logic below;
      logic leaves;
      logic shift_in;
      below = 1'b0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         leaves   = below | gone[i];
         shift_in = slot_v[i+1] & ~gone[i+1] & (~occ[i] | leaves);
         if (shift_in) begin
            q_nxt[i]   = woken[i+1];
            occ_nxt[i] = 1'b1;
         end else begin
            q_nxt[i]   = woken[i];
            occ_nxt[i] = occ[i] & ~leaves;
         end
         below = shift_in;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         occ <= '0;
      end else begin
         occ <= occ_nxt;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         q[i] <= q_nxt[i];
      end
   end

   // Full only blocks dispatch when nothing leaves this cycle.
   assign dq.ready = ~(&occ) | iq.done;
   assign iq.ready = |rdy;

   always_comb begin
      iq.opcode = q[0].opcode;
      iq.rdtag  = q[0].rdtag;
      iq.rsdata = q[0].rsdata;
      iq.rtdata = q[0].rtdata;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (sel[i]) begin
            iq.opcode = q[i].opcode;
            iq.rdtag  = q[i].rdtag;
            iq.rsdata = q[i].rsdata;
            iq.rtdata = q[i].rtdata;
         end
      end
   end

endmodule

//--- rtl/ooo_int_core.sv
`timescale 1ns/1ns

module ooo_int_core #(
   parameter int QUEUE_DEPTH = 4,
   parameter int MUL_LATENCY = 4
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         in_valid,
   input  logic [2:0]                   in_opcode,
   input  logic [ooo_pkg::AREG_W-1:0]   in_rd,
   input  logic [ooo_pkg::AREG_W-1:0]   in_rs,
   input  logic [ooo_pkg::AREG_W-1:0]   in_rt,
   input  logic [ooo_pkg::XLEN-1:0]     in_imm,
   output logic                         in_ready,
   output logic                         cdb_valid,
   output logic [ooo_pkg::TAG_W-1:0]    cdb_tag,
   output logic [ooo_pkg::XLEN-1:0]     cdb_data,
   input  logic [ooo_pkg::AREG_W-1:0]   dbg_addr,
   output logic [ooo_pkg::XLEN-1:0]     dbg_data
);

   dispatch_if                dq ();
   issue_if                   iq ();
   ooo_pkg::cdb_t             cdb;
   logic [ooo_pkg::AREG_W-1:0] lookup_rs;
   logic [ooo_pkg::AREG_W-1:0] lookup_rt;
   logic [ooo_pkg::TAG_W-1:0]  rs_tag;
   logic [ooo_pkg::TAG_W-1:0]  rt_tag;
   logic [ooo_pkg::XLEN-1:0]   rs_data;
   logic [ooo_pkg::XLEN-1:0]   rt_data;
   logic                       rs_valid;
   logic                       rt_valid;
   logic                       alloc_we;
   logic [ooo_pkg::AREG_W-1:0] alloc_rd;
   logic [ooo_pkg::TAG_W-1:0]  alloc_tag;

   assign cdb_valid = cdb.valid;
   assign cdb_tag   = cdb.tag;
   assign cdb_data  = cdb.data;

   dispatch_ctrl u_dispatch (
      .clk, .arst_n, .in_valid, .in_opcode, .in_rd, .in_rs, .in_rt, .in_imm, .in_ready,
      .lookup_rs, .lookup_rt, .rs_tag, .rs_data, .rs_valid, .rt_tag, .rt_data, .rt_valid,
      .alloc_we, .alloc_rd, .alloc_tag, .dq(dq.source)
   );

   register_status u_regs (
      .clk, .arst_n, .lookup_rs, .lookup_rt, .rs_tag, .rs_data, .rs_valid,
      .rt_tag, .rt_data, .rt_valid, .alloc_we, .alloc_rd, .alloc_tag, .cdb,
      .dbg_addr, .dbg_data
   );

   issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
      .clk, .arst_n, .dq(dq.sink), .cdb, .iq(iq.queue)
   );

   int_alu #(.MUL_LATENCY(MUL_LATENCY)) u_alu (
      .clk, .arst_n, .iq(iq.exec), .cdb
   );

endmodule

//--- rtl/ooo_pkg.sv
package ooo_pkg;

   localparam int XLEN   = 32;
   localparam int TAG_W  = 6;
   localparam int AREG_W = 3;

   // Tag 0 marks a register or operand with no pending producer.
   localparam logic [TAG_W-1:0] TAG_NONE  = '0;
   localparam logic [TAG_W-1:0] TAG_FIRST = TAG_W'(1);

   typedef enum logic [2:0] {
      op_add, op_sub, op_and, op_or, op_sll, op_srl, op_mul, op_li
   } op_e;

   // One result broadcast on the common data bus.
   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
      logic [XLEN-1:0]  data;
   } cdb_t;

   // Tags run 1 .. 63 and wrap back to 1, never handing out TAG_NONE.
   function automatic logic [TAG_W-1:0] next_tag(input logic [TAG_W-1:0] tag);
      return (tag == '1) ? TAG_FIRST : tag + 1'b1;
   endfunction

endpackage

//--- rtl/register_status.sv
`timescale 1ns/1ns

module register_status (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic [ooo_pkg::AREG_W-1:0]   lookup_rs,
   input  logic [ooo_pkg::AREG_W-1:0]   lookup_rt,
   output logic [ooo_pkg::TAG_W-1:0]    rs_tag,
   output logic [ooo_pkg::XLEN-1:0]     rs_data,
   output logic                         rs_valid,
   output logic [ooo_pkg::TAG_W-1:0]    rt_tag,
   output logic [ooo_pkg::XLEN-1:0]     rt_data,
   output logic                         rt_valid,
   input  logic                         alloc_we,
   input  logic [ooo_pkg::AREG_W-1:0]   alloc_rd,
   input  logic [ooo_pkg::TAG_W-1:0]    alloc_tag,
   input  ooo_pkg::cdb_t                cdb,
   input  logic [ooo_pkg::AREG_W-1:0]   dbg_addr,
   output logic [ooo_pkg::XLEN-1:0]     dbg_data
);

   localparam int NREG = 2 ** ooo_pkg::AREG_W;

   logic [ooo_pkg::XLEN-1:0]  regs [NREG];
   logic [ooo_pkg::TAG_W-1:0] pend [NREG];

   // True when the producer of a pending register broadcasts this very cycle.
   function automatic logic cdb_hit(input logic [ooo_pkg::TAG_W-1:0] tag);
      return cdb.valid && (cdb.tag == tag);
   endfunction

   // A source is ready if nothing is pending on it, or if its value is on the CDB
   // right now. In the second case the CDB data is forwarded.
   assign rs_tag   = pend[lookup_rs];
   assign rs_valid = (rs_tag == ooo_pkg::TAG_NONE) || cdb_hit(rs_tag);
   assign rs_data  = (rs_tag == ooo_pkg::TAG_NONE) ? regs[lookup_rs] : cdb.data;

   assign rt_tag   = pend[lookup_rt];
   assign rt_valid = (rt_tag == ooo_pkg::TAG_NONE) || cdb_hit(rt_tag);
   assign rt_data  = (rt_tag == ooo_pkg::TAG_NONE) ? regs[lookup_rt] : cdb.data;

   assign dbg_data = regs[dbg_addr];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NREG; i++) begin
            regs[i] <= '0;
            pend[i] <= ooo_pkg::TAG_NONE;
         end
      end else begin
         for (int i = 0; i < NREG; i++) begin
            if (cdb_hit(pend[i])) begin
               regs[i] <= cdb.data;
            end
            // A fresh rename wins over the write-back of the older producer.
            if (alloc_we && alloc_rd == ooo_pkg::AREG_W'(i)) begin
               pend[i] <= alloc_tag;
            end else if (cdb_hit(pend[i])) begin
               pend[i] <= ooo_pkg::TAG_NONE;
            end
         end
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and searches the log for the pass line.

cd "$(dirname "$0")" || exit 1

BUILD=build
LOG="$BUILD/sim.log"

if ! mkdir -p "$BUILD"; then
   echo "Cannot create the build directory"
   exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
      -Mdir "$BUILD/obj" -f files.f; then
   echo "Verilator build failed"
   exit 1
fi

if ! "$BUILD/obj/Vtb_top" +verilator+error+limit+100 > "$LOG" 2>&1; then
   cat "$LOG"
   echo "Simulation ended with an error status"
   exit 1
fi
cat "$LOG"

if grep -q "^RESULT: PASS$" "$LOG"; then
   exit 0
fi
exit 1
